// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

    // ------------------------------------------------
    // base opcodes
    // ------------------------------------------------
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    // alu funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // load/store widths
    localparam logic [2:0] f3_lb_sb = 3'b000;
    localparam logic [2:0] f3_lh_sh = 3'b001;
    localparam logic [2:0] f3_lw_sw = 3'b010;
    localparam logic [2:0] f3_lbu   = 3'b100;
    localparam logic [2:0] f3_lhu   = 3'b101;

    // ------------------------------------------------
    // instruction formats, msb first
    // ------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_inst_u;

endpackage

// File: design/id_ctrl_pkg.sv
package id_ctrl_pkg;

    // ------------------------------------------------
    // alu operation codes, consumed by execute
    // ------------------------------------------------
    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b    // lui
    } alu_op_e;

    // ------------------------------------------------
    // memory access width
    // ------------------------------------------------
    typedef enum logic [2-1:0] {
        mw_none = 2'd0,
        mw_byte = 2'd1,
        mw_half = 2'd2,
        mw_word = 2'd3
    } mem_width_e;

    // all-zero word, opcode 0 is not a valid rv32i opcode
    // so every control decodes inactive
    localparam logic [31:0] inst_bubble = 32'h0000_0000;

endpackage

// File: design/inst_hold.sv
`timescale 1ns/1ps

module inst_hold
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fetch_valid_i,
    input  logic [31:0] fetch_inst_i,
    input  logic        keep_i,
    input  logic        flush_i,
    output rv_inst_u    inst_o
);

    typedef enum logic [1:0] {
        st_pass,    // live fetch goes through
        st_held,    // replay of the buffered fetch
        st_kill     // one bubble after flush
    } hold_state_e;

    hold_state_e state_q, state_d;
    logic [31:0] buf_q;
    logic        full_q, full_d;

    // ------------------------------------------------
    // buffer and full mark
    // ------------------------------------------------
    always_comb begin
        if (keep_i && fetch_valid_i)
            full_d = 1'b1;
        else if (keep_i)
            full_d = full_q;          // hold during stall
        else
            full_d = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_q  <= '0;
            full_q <= 1'b0;
        end else begin
            full_q <= full_d;
            if (keep_i && fetch_valid_i)
                buf_q <= fetch_inst_i;
            else if (!keep_i && flush_i)
                buf_q <= '0;
            else if (!keep_i)
                buf_q <= fetch_inst_i;  // track fetch for a later stall
        end
    end

    // kill wins over a pending replay
    always_comb begin
        if (flush_i)
            state_d = st_kill;
        else if (full_d)
            state_d = st_held;
        else
            state_d = st_pass;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= st_pass;
        else
            state_q <= state_d;
    end

    // ------------------------------------------------
    // instruction seen by decode
    // ------------------------------------------------
    always_comb begin
        case (state_q)
            st_kill: inst_o = inst_bubble;
            st_held: inst_o = buf_q;
            default: begin
                if (keep_i)
                    inst_o = buf_q;
                else
                    inst_o = fetch_valid_i ? fetch_inst_i : inst_bubble;
            end
        endcase
    end

    a_flush_bubble: assert property (
        @(posedge clk) disable iff (!rst_n) flush_i |=> (inst_o == inst_bubble)
    ) else $error("no bubble after flush");

    a_full_needs_keep: assert property (
        @(posedge clk) disable iff (!rst_n) !keep_i |=> !$rose(full_q)
    ) else $error("buffer filled without keep");

endmodule

// File: design/ctrl_unit.sv
`timescale 1ns/1ps

module ctrl_unit
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  rv_inst_u   inst_i,
    output alu_op_e    alu_op_o,
    output logic       reg_we_o,
    output logic       op_b_imm_o,
    output logic       mem_en_o,
    output logic       mem_rd_o,
    output mem_width_e mem_width_o,
    output logic       mem_unsigned_o,
    output logic       rs1_re_o,
    output logic       rs2_re_o,
    output logic       branch_o,
    output logic       jump_o
);

    // funct3 to alu op, alt picks sub/sra
    function automatic alu_op_e alu_dec(input logic [2:0] f3, input logic sub_i,
                                        input logic sra_i);
        case (f3)
            f3_add_sub: alu_dec = sub_i ? alu_sub : alu_add;
            f3_sll:     alu_dec = alu_sll;
            f3_slt:     alu_dec = alu_slt;
            f3_sltu:    alu_dec = alu_sltu;
            f3_xor:     alu_dec = alu_xor;
            f3_srl_sra: alu_dec = sra_i ? alu_sra : alu_srl;
            f3_or:      alu_dec = alu_or;
            default:    alu_dec = alu_and;
        endcase
    endfunction

    logic [2:0]  funct3;
    logic        f7_alt;
    logic        imm_alt;      // bit 30 inside the i-format immediate
    mem_width_e  mem_w;
    logic        mem_u;

    assign funct3  = inst_i.r_fmt.funct3;
    assign f7_alt  = inst_i.r_fmt.funct7[5];
    assign imm_alt = inst_i.i_fmt.imm_11_0[10];

    // ------------------------------------------------
    // load/store width and sign
    // ------------------------------------------------
    always_comb begin
        mem_u = 1'b0;
        case (funct3)
            f3_lb_sb: mem_w = mw_byte;
            f3_lh_sh: mem_w = mw_half;
            f3_lw_sw: mem_w = mw_word;
            f3_lbu: begin
                mem_w = mw_byte;
                mem_u = 1'b1;
            end
            f3_lhu: begin
                mem_w = mw_half;
                mem_u = 1'b1;
            end
            default:  mem_w = mw_none;
        endcase
    end

    // ------------------------------------------------
    // main decode, bubble falls to default
    // ------------------------------------------------
    always_comb begin
        alu_op_o       = alu_add;
        reg_we_o       = 1'b0;
        op_b_imm_o     = 1'b0;
        mem_en_o       = 1'b0;
        mem_rd_o       = 1'b0;
        mem_width_o    = mw_none;
        mem_unsigned_o = 1'b0;
        rs1_re_o       = 1'b0;
        rs2_re_o       = 1'b0;
        branch_o       = 1'b0;
        jump_o         = 1'b0;
        case (inst_i.r_fmt.opcode)
            op_lui: begin
                alu_op_o   = alu_pass_b;
                reg_we_o   = 1'b1;
                op_b_imm_o = 1'b1;
            end
            op_auipc: begin
                reg_we_o   = 1'b1;
                op_b_imm_o = 1'b1;
            end
            op_jal: begin
                reg_we_o = 1'b1;    // link = pc + 4
                jump_o   = 1'b1;
            end
            op_jalr: begin
                reg_we_o = 1'b1;
                rs1_re_o = 1'b1;
                jump_o   = 1'b1;
            end
            op_branch: begin
                alu_op_o = alu_sub;
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
                branch_o = 1'b1;
            end
            op_load: begin
                reg_we_o       = 1'b1;
                op_b_imm_o     = 1'b1;
                rs1_re_o       = 1'b1;
                mem_en_o       = 1'b1;
                mem_rd_o       = 1'b1;
                mem_width_o    = mem_w;
                mem_unsigned_o = mem_u;
            end
            op_store: begin
                op_b_imm_o  = 1'b1;
                rs1_re_o    = 1'b1;
                rs2_re_o    = 1'b1;
                mem_en_o    = 1'b1;
                mem_width_o = mem_w;
            end
            op_imm: begin
                alu_op_o   = alu_dec(funct3, 1'b0, imm_alt);  // no subi
                reg_we_o   = 1'b1;
                op_b_imm_o = 1'b1;
                rs1_re_o   = 1'b1;
            end
            op_reg: begin
                alu_op_o = alu_dec(funct3, f7_alt, f7_alt);
                reg_we_o = 1'b1;
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        a_rd_needs_en: assert (!mem_rd_o || mem_en_o)
            else $error("mem_rd without mem_en");
    end

endmodule

// File: design/imm_gen.sv
`timescale 1ns/1ps

module imm_gen
    import rv_isa_pkg::*;
(
    input  rv_inst_u    inst_i,
    output logic [31:0] imm_o
);

    // ------------------------------------------------
    // format select by opcode
    // ------------------------------------------------
    always_comb begin
        case (inst_i.r_fmt.opcode)
            op_imm, op_load, op_jalr: begin
                imm_o = {{20{inst_i.i_fmt.imm_11_0[11]}}, inst_i.i_fmt.imm_11_0};
            end
            op_store: begin
                imm_o = {{20{inst_i.s_fmt.imm_11_5[6]}},
                         inst_i.s_fmt.imm_11_5,
                         inst_i.s_fmt.imm_4_0};
            end
            op_branch: begin
                // lsb always zero, halfword aligned
                imm_o = {{19{inst_i.b_fmt.imm_12}},
                         inst_i.b_fmt.imm_12,
                         inst_i.b_fmt.imm_11,
                         inst_i.b_fmt.imm_10_5,
                         inst_i.b_fmt.imm_4_1,
                         1'b0};
            end
            op_lui, op_auipc: begin
                imm_o = {inst_i.u_fmt.imm_31_12, 12'h000};
            end
            op_jal: begin
                imm_o = {{11{inst_i.j_fmt.imm_20}},
                         inst_i.j_fmt.imm_20,
                         inst_i.j_fmt.imm_19_12,
                         inst_i.j_fmt.imm_11,
                         inst_i.j_fmt.imm_10_1,
                         1'b0};
            end
            default: imm_o = '0;    // reg ops and bubble
        endcase
    end

endmodule

// File: design/operand_sel.sv
`timescale 1ns/1ps

module operand_sel
    import rv_isa_pkg::*;
(
    input  rv_inst_u    inst_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] imm_i,
    input  logic        op_b_imm_i,
    input  logic [31:0] rs1_rdata_i,
    input  logic [31:0] rs2_rdata_i,
    input  logic        fwd1_sel_i,
    input  logic        fwd2_sel_i,
    input  logic [31:0] fwd1_data_i,
    input  logic [31:0] fwd2_data_i,
    output logic [31:0] op_a_o,
    output logic [31:0] op_b_o,
    output logic [31:0] store_data_o,
    output logic [31:0] branch_target_o,
    output logic [31:0] jump_target_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        is_jump;
    logic        is_shift_imm;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;

    assign opcode       = inst_i.i_fmt.opcode;
    assign funct3       = inst_i.i_fmt.funct3;
    assign is_jump      = (opcode == op_jal) || (opcode == op_jalr);
    assign is_shift_imm = (opcode == op_imm) && ((funct3 == f3_sll) || (funct3 == f3_srl_sra));

    // ------------------------------------------------
    // forwarding
    // ------------------------------------------------
    assign rs1_val = fwd1_sel_i ? fwd1_data_i : rs1_rdata_i;
    assign rs2_val = fwd2_sel_i ? fwd2_data_i : rs2_rdata_i;

    always_comb begin
        if (opcode == op_lui)
            op_a_o = '0;
        else if ((opcode == op_auipc) || is_jump)
            op_a_o = pc_i;
        else
            op_a_o = rs1_val;
    end

    always_comb begin
        if (is_jump)
            op_b_o = 32'd4;                                   // link address
        else if (is_shift_imm)
            op_b_o = {27'd0, inst_i.i_fmt.imm_11_0[4:0]};     // shamt only
        else if (op_b_imm_i)
            op_b_o = imm_i;
        else
            op_b_o = rs2_val;
    end

    assign store_data_o    = rs2_val;
    assign branch_target_o = pc_i + imm_i;
    // jalr takes rs1 as base
    assign jump_target_o   = (opcode == op_jal) ? (pc_i + imm_i) : (rs1_val + imm_i);

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] pc_i,
    input  logic        fetch_valid_i,
    input  logic [31:0] fetch_inst_i,
    input  logic        keep_i,
    input  logic        flush_i,
    input  logic [31:0] rs1_rdata_i,
    input  logic [31:0] rs2_rdata_i,
    input  logic        fwd1_sel_i,
    input  logic        fwd2_sel_i,
    input  logic [31:0] fwd1_data_i,
    input  logic [31:0] fwd2_data_i,
    output logic [4:0]  rs1_addr_o,
    output logic [4:0]  rs2_addr_o,
    output logic [4:0]  rd_addr_o,
    output logic        rs1_re_o,
    output logic        rs2_re_o,
    output logic [31:0] op_a_o,
    output logic [31:0] op_b_o,
    output alu_op_e     alu_op_o,
    output logic        reg_we_o,
    output logic        mem_en_o,
    output logic        mem_rd_o,
    output mem_width_e  mem_width_o,
    output logic        mem_unsigned_o,
    output logic [31:0] store_data_o,
    output logic        branch_o,
    output logic [31:0] branch_target_o,
    output logic        jump_o,
    output logic [31:0] jump_target_o
);

    rv_inst_u    cur_inst;   // held or live instruction
    logic        op_b_imm;
    logic [31:0] imm;

    // register addresses straight from the r view
    assign rs1_addr_o = cur_inst.r_fmt.rs1;
    assign rs2_addr_o = cur_inst.r_fmt.rs2;
    assign rd_addr_o  = cur_inst.r_fmt.rd;

    inst_hold u_inst_hold (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid_i (fetch_valid_i),
        .fetch_inst_i  (fetch_inst_i),
        .keep_i        (keep_i),
        .flush_i       (flush_i),
        .inst_o        (cur_inst)
    );

    ctrl_unit u_ctrl_unit (
        .inst_i         (cur_inst),
        .alu_op_o       (alu_op_o),
        .reg_we_o       (reg_we_o),
        .op_b_imm_o     (op_b_imm),
        .mem_en_o       (mem_en_o),
        .mem_rd_o       (mem_rd_o),
        .mem_width_o    (mem_width_o),
        .mem_unsigned_o (mem_unsigned_o),
        .rs1_re_o       (rs1_re_o),
        .rs2_re_o       (rs2_re_o),
        .branch_o       (branch_o),
        .jump_o         (jump_o)
    );

    imm_gen u_imm_gen (
        .inst_i (cur_inst),
        .imm_o  (imm)
    );

    operand_sel u_operand_sel (
        .inst_i          (cur_inst),
        .pc_i            (pc_i),
        .imm_i           (imm),
        .op_b_imm_i      (op_b_imm),
        .rs1_rdata_i     (rs1_rdata_i),
        .rs2_rdata_i     (rs2_rdata_i),
        .fwd1_sel_i      (fwd1_sel_i),
        .fwd2_sel_i      (fwd2_sel_i),
        .fwd1_data_i     (fwd1_data_i),
        .fwd2_data_i     (fwd2_data_i),
        .op_a_o          (op_a_o),
        .op_b_o          (op_b_o),
        .store_data_o    (store_data_o),
        .branch_target_o (branch_target_o),
        .jump_target_o   (jump_target_o)
    );

endmodule

// File: verif/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk_o
);

    localparam int half_period_ns = 20;    // 40 ns period

    initial begin
        clk_o = 1'b0;
    end

    always #(half_period_ns) clk_o = ~clk_o;

endmodule

// File: verif/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;

    localparam int clk_period_ns = 40;
    localparam int reset_cycles  = 10;
    localparam int max_vectors   = 64;
    localparam int n_cols        = 14;

    logic        clk;
    logic        rst_n;
    logic [31:0] pc_i;
    logic        fetch_valid_i;
    logic [31:0] fetch_inst_i;
    logic        keep_i;
    logic        flush_i;
    logic [31:0] rs1_rdata_i;
    logic [31:0] rs2_rdata_i;
    logic        fwd1_sel_i;
    logic        fwd2_sel_i;
    logic [31:0] fwd1_data_i;
    logic [31:0] fwd2_data_i;

    logic [4:0]  rs1_addr_o;
    logic [4:0]  rs2_addr_o;
    logic [4:0]  rd_addr_o;
    logic        rs1_re_o;
    logic        rs2_re_o;
    logic [31:0] op_a_o;
    logic [31:0] op_b_o;
    logic [4:0]  alu_op_o;
    logic        reg_we_o;
    logic        mem_en_o;
    logic        mem_rd_o;
    logic [1:0]  mem_width_o;
    logic        mem_unsigned_o;
    logic [31:0] store_data_o;
    logic        branch_o;
    logic [31:0] branch_target_o;
    logic        jump_o;
    logic [31:0] jump_target_o;

    // inputs flags pc inst rs1 rs2 fwd1 fwd2
    // then expected regs ctl op_a op_b sdata btgt jtgt
    logic [31:0] vec_mem [0:max_vectors-1][0:n_cols-1];
    int          n_vec;
    logic        loaded;

    clk_gen u_clk_gen (
        .clk_o (clk)
    );

    decode_stage dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .pc_i            (pc_i),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_inst_i    (fetch_inst_i),
        .keep_i          (keep_i),
        .flush_i         (flush_i),
        .rs1_rdata_i     (rs1_rdata_i),
        .rs2_rdata_i     (rs2_rdata_i),
        .fwd1_sel_i      (fwd1_sel_i),
        .fwd2_sel_i      (fwd2_sel_i),
        .fwd1_data_i     (fwd1_data_i),
        .fwd2_data_i     (fwd2_data_i),
        .rs1_addr_o      (rs1_addr_o),
        .rs2_addr_o      (rs2_addr_o),
        .rd_addr_o       (rd_addr_o),
        .rs1_re_o        (rs1_re_o),
        .rs2_re_o        (rs2_re_o),
        .op_a_o          (op_a_o),
        .op_b_o          (op_b_o),
        .alu_op_o        (alu_op_o),
        .reg_we_o        (reg_we_o),
        .mem_en_o        (mem_en_o),
        .mem_rd_o        (mem_rd_o),
        .mem_width_o     (mem_width_o),
        .mem_unsigned_o  (mem_unsigned_o),
        .store_data_o    (store_data_o),
        .branch_o        (branch_o),
        .branch_target_o (branch_target_o),
        .jump_o          (jump_o),
        .jump_target_o   (jump_target_o)
    );

    // --------------------------------------------------
    // vector file
    // --------------------------------------------------
    task automatic load_vectors();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] w [0:n_cols-1];
        fd = $fopen("verif/decode_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display("Test FAILED");
            $fatal(1, "missing stimulus");
        end
        n_vec = 0;
        while (!$feof(fd) && n_vec < max_vectors) begin
            line = "";
            void'($fgets(line, fd));
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          w[0], w[1], w[2], w[3], w[4], w[5], w[6],
                          w[7], w[8], w[9], w[10], w[11], w[12], w[13]);
            if (cnt == n_cols) begin    // comments and blank lines fall out here
                for (int c = 0; c < n_cols; c++)
                    vec_mem[n_vec][c] = w[c];
                n_vec++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input int i);
        fetch_valid_i <= vec_mem[i][0][4];
        keep_i        <= vec_mem[i][0][3];
        flush_i       <= vec_mem[i][0][2];
        fwd1_sel_i    <= vec_mem[i][0][1];
        fwd2_sel_i    <= vec_mem[i][0][0];
        pc_i          <= vec_mem[i][1];
        fetch_inst_i  <= vec_mem[i][2];
        rs1_rdata_i   <= vec_mem[i][3];
        rs2_rdata_i   <= vec_mem[i][4];
        fwd1_data_i   <= vec_mem[i][5];
        fwd2_data_i   <= vec_mem[i][6];
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp) else begin
            $display("error: %s expected %h got %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_vector(input int i);
        logic [31:0] regs;
        logic [31:0] ctl;
        regs = vec_mem[i][7];
        ctl  = vec_mem[i][8];
        check_word("rs1_addr_o", 32'(regs[14:10]), 32'(rs1_addr_o));
        check_word("rs2_addr_o", 32'(regs[9:5]), 32'(rs2_addr_o));
        check_word("rd_addr_o", 32'(regs[4:0]), 32'(rd_addr_o));
        check_word("alu_op_o", 32'(ctl[14:10]), 32'(alu_op_o));
        check_word("mem_width_o", 32'(ctl[9:8]), 32'(mem_width_o));
        check_word("rs1_re_o", 32'(ctl[7]), 32'(rs1_re_o));
        check_word("rs2_re_o", 32'(ctl[6]), 32'(rs2_re_o));
        check_word("reg_we_o", 32'(ctl[5]), 32'(reg_we_o));
        check_word("mem_en_o", 32'(ctl[4]), 32'(mem_en_o));
        check_word("mem_rd_o", 32'(ctl[3]), 32'(mem_rd_o));
        check_word("mem_unsigned_o", 32'(ctl[2]), 32'(mem_unsigned_o));
        check_word("branch_o", 32'(ctl[1]), 32'(branch_o));
        check_word("jump_o", 32'(ctl[0]), 32'(jump_o));
        check_word("op_a_o", vec_mem[i][9], op_a_o);
        check_word("op_b_o", vec_mem[i][10], op_b_o);
        check_word("store_data_o", vec_mem[i][11], store_data_o);
        check_word("branch_target_o", vec_mem[i][12], branch_target_o);
        check_word("jump_target_o", vec_mem[i][13], jump_target_o);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        rst_n         = 1'b0;
        pc_i          = '0;
        fetch_valid_i = 1'b0;
        fetch_inst_i  = '0;
        keep_i        = 1'b0;
        flush_i       = 1'b0;
        rs1_rdata_i   = '0;
        rs2_rdata_i   = '0;
        fwd1_sel_i    = 1'b0;
        fwd2_sel_i    = 1'b0;
        fwd1_data_i   = '0;
        fwd2_data_i   = '0;
        loaded        = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_vec; i++) begin
            @(posedge clk);
            drive_vector(i);
            @(negedge clk);    // outputs settled half a cycle before the next edge
            check_vector(i);
        end
        @(posedge clk);
        $display("Test OK");
        $finish;
    end

    // watchdog sized from the vector count
    initial begin
        wait (loaded);
        #((n_vec + reset_cycles + 20) * clk_period_ns);
        $display("the stimulus did not finish in time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: verif/decode_stimulus.txt
# in : flags{valid,keep,flush,fwd1_sel,fwd2_sel} pc inst rs1 rs2 fwd1 fwd2
# exp: regs{rs1,rs2,rd} ctl{alu,width,re1,re2,we,men,mrd,uns,br,jmp} op_a op_b sdata btgt jtgt
00 0 0 1000 200 aaaa0000 bbbb 0000 0000 1000 200 200 0 1000
10 100 002081b3 1000 200 aaaa0000 bbbb 0443 00e0 1000 200 200 100 1000
10 104 402081b3 1000 200 aaaa0000 bbbb 0443 04e0 1000 200 200 104 1000
10 108 4020d1b3 1000 200 aaaa0000 bbbb 0443 1ce0 1000 200 200 108 1000
10 10c ffb08193 1000 200 aaaa0000 bbbb 0763 00a0 1000 fffffffb 200 107 ffb
10 110 00709193 1000 200 aaaa0000 bbbb 04e3 08a0 1000 7 200 117 1007
10 114 4030d193 1000 200 aaaa0000 bbbb 0463 1ca0 1000 3 200 517 1403
10 118 0080a183 1000 200 aaaa0000 bbbb 0503 03b8 1000 8 200 120 1008
10 11c fff0c183 1000 200 aaaa0000 bbbb 07e3 01bc 1000 ffffffff 200 11b fff
10 120 00209623 1000 200 aaaa0000 bbbb 044c 02d0 1000 c 200 12c 100c
11 124 fe20ae23 1000 200 aaaa0000 bbbb 045c 03d0 1000 fffffffc bbbb 120 ffc
10 200 00208863 1000 200 aaaa0000 bbbb 0450 04c2 1000 200 200 210 1010
13 300 fe209ce3 1000 200 aaaa0000 bbbb 0459 04c2 aaaa0000 bbbb bbbb 2f8 aaa9fff8
10 400 001000ef 1000 200 aaaa0000 bbbb 0021 0021 400 4 200 c00 c00
12 500 010280e7 1000 200 aaaa0000 bbbb 1601 00a1 500 4 200 510 aaaa0010
10 600 123451b7 1000 200 aaaa0000 bbbb 2063 2820 0 12345000 200 12345600 12346000
10 700 00001197 1000 200 aaaa0000 bbbb 0003 0020 700 1000 200 1700 2000
14 800 002081b3 1000 200 aaaa0000 bbbb 0443 00e0 1000 200 200 800 1000
10 804 002081b3 1000 200 aaaa0000 bbbb 0000 0000 1000 200 200 804 1000
10 808 002081b3 1000 200 aaaa0000 bbbb 0443 00e0 1000 200 200 808 1000
18 900 402081b3 1000 200 aaaa0000 bbbb 0443 00e0 1000 200 200 900 1000
18 904 402081b3 1000 200 aaaa0000 bbbb 0443 04e0 1000 200 200 904 1000
10 908 0020f1b3 1000 200 aaaa0000 bbbb 0443 04e0 1000 200 200 908 1000
10 90c 0020e1b3 1000 200 aaaa0000 bbbb 0443 20e0 1000 200 200 90c 1000
00 a00 0020e1b3 1000 200 aaaa0000 bbbb 0000 0000 1000 200 200 a00 1000

// File: tb.f
design/rv_isa_pkg.sv
design/id_ctrl_pkg.sv
design/inst_hold.sv
design/ctrl_unit.sv
design/imm_gen.sv
design/operand_sel.sv
design/decode_stage.sv
verif/clk_gen.sv
verif/tb_decode_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
LOG       ?= sim.log

SIM  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' tb.f)

.PHONY: build run clean

build: $(SIM)

$(SIM): $(SRCS) tb.f
	$(VERILATOR) --binary --timing --assert -f tb.f --top-module $(TOP)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "pass line missing from $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
